// ==== hw/bus_pkg.sv ====
`default_nettype none

package bus_pkg;

    // fetch side, valid held until addr_ok
    typedef struct packed {
        logic        valid;
        logic [31:0] addr;
    } ibus_req_t;

    typedef struct packed {
        logic        addr_ok;
        logic        data_ok;
        logic [63:0] data;
    } ibus_resp_t;

    // bytes per beat
    typedef enum logic [2:0] {
        MSIZE1,
        MSIZE2,
        MSIZE4,
        MSIZE8
    } msize_t;

    // beats per burst, minus one
    typedef enum logic [3:0] {
        MLEN1  = 4'd0,
        MLEN2  = 4'd1,
        MLEN4  = 4'd3,
        MLEN8  = 4'd7,
        MLEN16 = 4'd15
    } mlen_t;

    typedef struct packed {
        logic        valid;
        logic        is_write;
        msize_t      size;
        logic [31:0] addr;
        logic [7:0]  strobe;
        logic [63:0] data;
        mlen_t       len;
    } cbus_req_t;

    typedef struct packed {
        logic        ready;
        logic        last;
        logic [31:0] data;
    } cbus_resp_t;

endpackage

`default_nettype wire

// ==== hw/icache_pkg.sv ====
`default_nettype none

package icache_pkg;

    localparam int WAYS           = 4;
    localparam int SETS           = 16;
    localparam int DATA_PER_LINE  = 8;
    localparam int WORDS_PER_LINE = 16;

    localparam int DATA_WIDTH    = 64;
    localparam int WORD_WIDTH    = 32;
    localparam int WAY_BITS      = $clog2(WAYS);
    localparam int INDEX_BITS    = $clog2(SETS);
    localparam int OFFSET_BITS   = $clog2(DATA_PER_LINE);
    localparam int ALIGN_BITS    = $clog2(DATA_WIDTH / 8);
    localparam int WORD_IDX_BITS = $clog2(WORDS_PER_LINE);
    localparam int TAG_BITS      = 32 - INDEX_BITS - OFFSET_BITS - ALIGN_BITS;
    localparam int DATA_DEPTH    = WAYS * SETS * DATA_PER_LINE;

    typedef logic [TAG_BITS-1:0]      tag_t;
    typedef logic [INDEX_BITS-1:0]    index_t;
    typedef logic [OFFSET_BITS-1:0]   offset_t;
    typedef logic [WAY_BITS-1:0]      way_t;
    typedef logic [WORD_IDX_BITS-1:0] word_idx_t;
    typedef logic [DATA_WIDTH-1:0]    data_t;
    typedef logic [WORD_WIDTH-1:0]    word_t;

    // tree bits, [0] is the root
    typedef logic [WAYS-2:0] plru_t;

    typedef struct packed {
        tag_t                  tag;
        index_t                index;
        offset_t               offset;
        logic [ALIGN_BITS-1:0] align;
    } addr_t;

    typedef struct packed {
        logic valid;
        tag_t tag;
    } meta_t;

    typedef struct packed {
        way_t    way;
        index_t  index;
        offset_t offset;
    } data_addr_t;

    typedef struct packed {
        addr_t addr;
        way_t  way;
    } refill_info_t;

    typedef enum logic {
        IDLE,
        FETCH
    } refill_state_t;

endpackage

`default_nettype wire

// ==== hw/icache_tag_array.sv ====
`timescale 1ns/1ns
`default_nettype none

module icache_tag_array (
    input  logic               clk,
    input  logic               resetn,
    input  icache_pkg::addr_t  lookup_addr,
    output logic               lookup_hit,
    output icache_pkg::way_t   hit_way,
    output icache_pkg::way_t   victim_way,
    input  logic               touch,
    input  logic               alloc
);

    import icache_pkg::*;

    meta_t meta [SETS][WAYS];
    plru_t plru [SETS];

    index_t idx;
    plru_t  plru_cur;
    plru_t  plru_next;

    assign idx      = lookup_addr.index;
    assign plru_cur = plru[idx];

    // lowest matching way wins
    always_comb begin
        lookup_hit = 1'b0;
        hit_way    = '0;
        for (int w = WAYS - 1; w >= 0; w--) begin
            if (meta[idx][w].valid && meta[idx][w].tag == lookup_addr.tag) begin
                lookup_hit = 1'b1;
                hit_way    = way_t'(w);
            end
        end
    end

    // follow the tree toward the side marked for replacement
    always_comb begin
        if (plru_cur[0]) begin
            victim_way = {1'b1, plru_cur[2]};
        end else begin
            victim_way = {1'b0, plru_cur[1]};
        end
    end

    // point every node on the hit path away from the hit way
    always_comb begin
        plru_next    = plru_cur;
        plru_next[0] = ~hit_way[1];
        if (hit_way[1]) begin
            plru_next[2] = ~hit_way[0];
        end else begin
            plru_next[1] = ~hit_way[0];
        end
    end

    always_ff @(posedge clk) begin
        if (resetn) begin
            for (int s = 0; s < SETS; s++) begin
                plru[s] <= '0;
                for (int w = 0; w < WAYS; w++) begin
                    meta[s][w].valid <= 1'b0;
                end
            end
        end else begin
            if (alloc) begin
                meta[idx][victim_way].valid <= 1'b1;
                meta[idx][victim_way].tag   <= lookup_addr.tag;
            end
            if (touch) begin
                plru[idx] <= plru_next;
            end
        end
    end

    // the controller never accepts a hit and a miss together
    a_touch_alloc_excl: assert property (
        @(posedge clk) disable iff (resetn)
        !(touch && alloc)
    );

endmodule

`default_nettype wire

// ==== hw/icache_data_array.sv ====
`timescale 1ns/1ns
`default_nettype none

module icache_data_array (
    input  logic                   clk,
    input  logic                   rd_en,
    input  icache_pkg::data_addr_t rd_addr,
    output icache_pkg::data_t      rd_data,
    input  logic                   wr_en,
    input  icache_pkg::data_addr_t wr_addr,
    input  logic                   wr_upper,
    input  icache_pkg::word_t      wr_word
);

    import icache_pkg::*;

    // one entry per way, set and offset
    data_t mem [DATA_DEPTH];

    // read first, a same-cycle write shows up on the next read
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

    // each beat fills one half of an entry
    always_ff @(posedge clk) begin
        if (wr_en) begin
            if (wr_upper) begin
                mem[wr_addr][DATA_WIDTH-1:WORD_WIDTH] <= wr_word;
            end else begin
                mem[wr_addr][WORD_WIDTH-1:0] <= wr_word;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/icache_fill_tracker.sv ====
`timescale 1ns/1ns
`default_nettype none

module icache_fill_tracker (
    input  logic                                  clk,
    input  logic                                  resetn,
    input  logic                                  start,
    input  icache_pkg::word_idx_t                 start_word,
    input  logic                                  beat,
    output icache_pkg::word_idx_t                 fill_word,
    output logic [icache_pkg::WORDS_PER_LINE-1:0] word_done
);

    import icache_pkg::*;

    word_idx_t                 count;
    logic [WORDS_PER_LINE-1:0] arrived;

    always_ff @(posedge clk) begin
        if (resetn) begin
            count   <= '0;
            arrived <= '0;
        end else if (start) begin
            count   <= start_word;
            arrived <= '0;
        end else if (beat) begin
            arrived[count] <= 1'b1;
            // wraps within the line
            count <= count + 1'b1;
        end
    end

    assign fill_word = count;

    // an entry is readable only with both halves in place
    for (genvar i = 0; i < WORDS_PER_LINE; i += 2) begin : g_entry
        assign word_done[i]   = arrived[i] & arrived[i+1];
        assign word_done[i+1] = arrived[i] & arrived[i+1];
    end

    // a new miss is only taken once the last beat is in
    a_no_beat_on_start: assert property (
        @(posedge clk) disable iff (resetn)
        !(start && beat)
    );

endmodule

`default_nettype wire

// ==== hw/icache_refill_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module icache_refill_ctrl (
    input  logic                                  clk,
    input  logic                                  resetn,
    input  bus_pkg::ibus_req_t                    ireq,
    input  logic                                  lookup_hit,
    input  icache_pkg::way_t                      hit_way,
    input  icache_pkg::way_t                      victim_way,
    input  logic [icache_pkg::WORDS_PER_LINE-1:0] word_done,
    input  icache_pkg::word_idx_t                 fill_word,
    input  bus_pkg::cbus_resp_t                   icresp,
    output logic                                  touch,
    output logic                                  alloc,
    output logic                                  start,
    output logic                                  beat,
    output logic                                  rd_en,
    output icache_pkg::data_addr_t                rd_addr,
    output logic                                  wr_en,
    output icache_pkg::data_addr_t                wr_addr,
    output logic                                  wr_upper,
    output icache_pkg::word_t                     wr_word,
    output logic                                  addr_ok,
    output logic                                  data_ok,
    output bus_pkg::cbus_req_t                    icreq
);

    import bus_pkg::*;
    import icache_pkg::*;

    refill_state_t state;
    refill_info_t  info;
    addr_t         req;
    word_idx_t     req_word;
    logic          other_line;
    logic          hit_ok;
    logic          miss_ok;

    assign req      = ireq.addr;
    assign req_word = {req.offset, req.align[ALIGN_BITS-1]};

    assign other_line = {req.tag, req.index} != {info.addr.tag, info.addr.index};
    assign hit_ok  = ireq.valid & lookup_hit
                   & (state == IDLE | other_line | word_done[req_word]);
    assign miss_ok = ireq.valid & ~lookup_hit & (state == IDLE);

    assign addr_ok = hit_ok;
    assign touch   = hit_ok;
    assign alloc   = miss_ok;
    assign start   = miss_ok;
    assign beat    = (state == FETCH) & icresp.ready;

    assign rd_en   = hit_ok;
    assign rd_addr = '{way: hit_way, index: req.index, offset: req.offset};

    // beats land in the victim way at the tracker's word
    assign wr_en    = beat;
    assign wr_addr  = '{way: info.way, index: info.addr.index,
                        offset: fill_word[WORD_IDX_BITS-1:1]};
    assign wr_upper = fill_word[0];
    assign wr_word  = icresp.data;

    always_ff @(posedge clk) begin
        if (resetn) begin
            state   <= IDLE;
            data_ok <= 1'b0;
        end else begin
            data_ok <= hit_ok;
            unique case (state)
                IDLE: begin
                    if (miss_ok) begin
                        state <= FETCH;
                    end
                end
                FETCH: begin
                    if (beat && icresp.last) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (miss_ok) begin
            info <= '{addr: req, way: victim_way};
        end
    end

    // burst starts at the critical word and memory wraps it
    assign icreq.valid    = state == FETCH;
    assign icreq.is_write = 1'b0;
    assign icreq.size     = MSIZE4;
    assign icreq.addr     = info.addr;
    assign icreq.strobe   = '0;
    assign icreq.data     = '0;
    assign icreq.len      = MLEN16;

    // memory answers only a request we raised
    a_ready_in_fetch: assert property (
        @(posedge clk) disable iff (resetn)
        icresp.ready |-> state == FETCH
    );

endmodule

`default_nettype wire

// ==== hw/icache.sv ====
`timescale 1ns/1ns
`default_nettype none

module icache (
    input  logic                clk,
    input  logic                resetn,
    input  bus_pkg::ibus_req_t  ireq,
    output bus_pkg::ibus_resp_t iresp,
    output bus_pkg::cbus_req_t  icreq,
    input  bus_pkg::cbus_resp_t icresp
);

    import icache_pkg::*;

    addr_t                     lookup_addr;
    logic                      lookup_hit;
    way_t                      hit_way;
    way_t                      victim_way;
    logic                      touch;
    logic                      alloc;
    logic                      start;
    word_idx_t                 start_word;
    logic                      beat;
    word_idx_t                 fill_word;
    logic [WORDS_PER_LINE-1:0] word_done;
    logic                      rd_en;
    data_addr_t                rd_addr;
    data_t                     rd_data;
    logic                      wr_en;
    data_addr_t                wr_addr;
    logic                      wr_upper;
    word_t                     wr_word;
    logic                      addr_ok;
    logic                      data_ok;

    assign lookup_addr = ireq.addr;
    // critical word of the missing request
    assign start_word  = {lookup_addr.offset, lookup_addr.align[ALIGN_BITS-1]};

    icache_tag_array i_tag_array (
        .clk        (clk),
        .resetn     (resetn),
        .lookup_addr(lookup_addr),
        .lookup_hit (lookup_hit),
        .hit_way    (hit_way),
        .victim_way (victim_way),
        .touch      (touch),
        .alloc      (alloc)
    );

    icache_data_array i_data_array (
        .clk     (clk),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (rd_data),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_upper(wr_upper),
        .wr_word (wr_word)
    );

    icache_fill_tracker i_fill_tracker (
        .clk       (clk),
        .resetn    (resetn),
        .start     (start),
        .start_word(start_word),
        .beat      (beat),
        .fill_word (fill_word),
        .word_done (word_done)
    );

    icache_refill_ctrl i_refill_ctrl (
        .clk       (clk),
        .resetn    (resetn),
        .ireq      (ireq),
        .lookup_hit(lookup_hit),
        .hit_way   (hit_way),
        .victim_way(victim_way),
        .word_done (word_done),
        .fill_word (fill_word),
        .icresp    (icresp),
        .touch     (touch),
        .alloc     (alloc),
        .start     (start),
        .beat      (beat),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_upper  (wr_upper),
        .wr_word   (wr_word),
        .addr_ok   (addr_ok),
        .data_ok   (data_ok),
        .icreq     (icreq)
    );

    assign iresp.addr_ok = addr_ok;
    assign iresp.data_ok = data_ok;
    assign iresp.data    = rd_data;

endmodule

`default_nettype wire

// ==== tests/icache_mem_model.sv ====
`timescale 1ns/1ns
`default_nettype none

module icache_mem_model #(
    parameter logic [31:0] seed = 32'hc8f1_a990
) (
    input  logic                clk,
    input  logic                resetn,
    input  bus_pkg::cbus_req_t  icreq,
    output bus_pkg::cbus_resp_t icresp
);

    logic [31:0] lfsr = seed;

    // galois lfsr, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return r;
    endfunction

    function automatic logic [31:0] word_value(input logic [29:0] w);
        return {2'b00, w} * 32'h9e37_79b1 + 32'h1234_5678;
    endfunction

    // one wrapped line, critical word first
    task automatic serve_burst();
        logic [31:0] base;
        logic [3:0]  word;
        int          wait_cycles;
        base = icreq.addr;
        word = base[5:2];
        wait_cycles = int'(rand_bits(3));
        repeat (wait_cycles) begin
            @(posedge clk);
            #1;
        end
        for (int k = 0; k < 16; k++) begin
            wait_cycles = (rand_bits(2) == 0) ? int'(rand_bits(2)) : 0;
            repeat (wait_cycles) begin
                @(posedge clk);
                #1;
            end
            icresp.ready = 1'b1;
            icresp.last  = (k == 15);
            icresp.data  = word_value({base[31:6], word});
            @(posedge clk);
            #1;
            icresp = '0;
            word   = word + 1'b1;
        end
    endtask

    initial begin
        icresp = '0;
        forever begin
            @(posedge clk);
            #1;
            if (!resetn && icreq.valid) begin
                serve_burst();
            end
        end
    end

endmodule

`default_nettype wire

// ==== tests/icache_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module icache_tb;

    import bus_pkg::*;
    import icache_pkg::*;

    localparam logic [31:0] lfsr_seed      = 32'hc8f1_a990;
    localparam int          num_requests   = 400;
    localparam int          timeout_cycles = 2000;

    logic       clk;
    logic       resetn;
    ibus_req_t  ireq;
    ibus_resp_t iresp;
    cbus_req_t  icreq;
    cbus_resp_t icresp;

    // reference cache state
    tag_t  model_tag   [SETS][WAYS];
    logic  model_valid [SETS][WAYS];
    plru_t model_plru  [SETS];

    logic        checking;
    logic        busy;
    logic        busy_prev;
    logic        req_valid_prev;
    logic [31:0] refill_addr;
    logic [15:0] arrived;
    int          beat_count;
    logic        data_expected;
    logic [63:0] data_exp;
    logic [31:0] lfsr;
    int          error_count;
    int          miss_count;
    int          req_count;
    int          hit_count;
    int          refill_hit_count;

    icache i_icache (
        .clk   (clk),
        .resetn(resetn),
        .ireq  (ireq),
        .iresp (iresp),
        .icreq (icreq),
        .icresp(icresp)
    );

    icache_mem_model #(
        .seed(lfsr_seed)
    ) i_mem_model (
        .clk   (clk),
        .resetn(resetn),
        .icreq (icreq),
        .icresp(icresp)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return r;
    endfunction

    function automatic logic [31:0] word_value(input logic [29:0] w);
        return {2'b00, w} * 32'h9e37_79b1 + 32'h1234_5678;
    endfunction

    // six tags over sets 3 and 12
    function automatic logic [31:0] next_addr();
        logic [31:0] t;
        logic [31:0] low;
        logic [3:0]  set;
        t   = rand_bits(3) % 6;
        set = rand_bits(1) ? 4'd12 : 4'd3;
        low = rand_bits(4);
        return {22'h2a_c000 + t[21:0], set, low[3:0], 2'b00};
    endfunction

    function automatic int find_way(input logic [31:0] a);
        int found;
        found = -1;
        for (int w = 0; w < WAYS; w++) begin
            if (model_valid[a[9:6]][w] && model_tag[a[9:6]][w] == a[31:10]) begin
                found = w;
            end
        end
        return found;
    endfunction

    // each tree bit names the half to replace
    function automatic int pick_victim(input plru_t p);
        if (p[0]) begin
            return 2 + int'(p[2]);
        end
        return int'(p[1]);
    endfunction

    function automatic plru_t touched(input plru_t p, input int w);
        plru_t n;
        n    = p;
        n[0] = (w < 2);
        if (w < 2) begin
            n[1] = (w == 0);
        end else begin
            n[2] = (w == 2);
        end
        return n;
    endfunction

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        error_count++;
        $display("CHECK FAILED at %0t: %s got %h, expected %h", $time, name, got, exp);
    endtask

    task automatic report_error(input string msg);
        error_count++;
        $display("ERROR at %0t: %s", $time, msg);
    endtask

    task automatic check_data_ok();
        if (iresp.data_ok !== data_expected) begin
            report_mismatch("iresp.data_ok", iresp.data_ok, data_expected);
        end else if (data_expected && iresp.data !== data_exp) begin
            report_mismatch("iresp.data", iresp.data, data_exp);
        end
        data_expected = 1'b0;
    endtask

    task automatic check_mem_req();
        if (icreq.valid !== busy) begin
            report_mismatch("icreq.valid", icreq.valid, busy);
        end
        if (icreq.valid && !req_valid_prev) begin
            req_count++;
            if (icreq.addr !== refill_addr) begin
                report_mismatch("icreq.addr", icreq.addr, refill_addr);
            end
            if (icreq.is_write !== 1'b0) begin
                report_mismatch("icreq.is_write", icreq.is_write, 1'b0);
            end
            if (icreq.size !== MSIZE4) begin
                report_mismatch("icreq.size", icreq.size, MSIZE4);
            end
            if (icreq.len !== MLEN16) begin
                report_mismatch("icreq.len", icreq.len, MLEN16);
            end
            if (icreq.strobe !== 8'h00) begin
                report_mismatch("icreq.strobe", icreq.strobe, 8'h00);
            end
            if (icreq.data !== 64'h0) begin
                report_mismatch("icreq.data", icreq.data, 64'h0);
            end
        end
        req_valid_prev = icreq.valid;
    endtask

    // predicts acceptance from the reference state before this edge
    task automatic eval_request();
        logic [31:0] a;
        int          way;
        int          victim;
        logic        entry_in;
        logic        exp_ok;
        a      = ireq.addr;
        exp_ok = 1'b0;
        if (ireq.valid) begin
            way      = find_way(a);
            entry_in = arrived[{a[5:3], 1'b0}] & arrived[{a[5:3], 1'b1}];
            exp_ok   = way >= 0 && (!busy || a[31:6] != refill_addr[31:6] || entry_in);
            if (way < 0 && !busy) begin
                victim = pick_victim(model_plru[a[9:6]]);
                model_tag[a[9:6]][victim]   = a[31:10];
                model_valid[a[9:6]][victim] = 1'b1;
                busy        = 1'b1;
                refill_addr = a;
                arrived     = '0;
                beat_count  = 0;
                miss_count++;
            end
        end
        if (iresp.addr_ok !== exp_ok) begin
            report_mismatch("iresp.addr_ok", iresp.addr_ok, exp_ok);
        end
        if (exp_ok) begin
            model_plru[a[9:6]] = touched(model_plru[a[9:6]], way);
            data_expected = 1'b1;
            data_exp = {word_value({a[31:3], 1'b1}), word_value({a[31:3], 1'b0})};
            hit_count++;
            if (busy) begin
                refill_hit_count++;
            end
        end
    endtask

    task automatic track_beats();
        logic [3:0] widx;
        if (icresp.ready) begin
            if (!busy_prev) begin
                report_error("memory beat outside a refill");
            end else begin
                widx = refill_addr[5:2] + 4'(beat_count);
                arrived[widx] = 1'b1;
                beat_count++;
                if (icresp.last) begin
                    if (beat_count != 16) begin
                        report_mismatch("icresp.last beat", beat_count, 16);
                    end
                    busy = 1'b0;
                end
            end
        end
    endtask

    always @(negedge clk) begin
        if (checking) begin
            busy_prev = busy;
            check_data_ok();
            check_mem_req();
            eval_request();
            track_beats();
        end
    end

    task automatic wait_accept(output logic ok);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!iresp.addr_ok && cycles < timeout_cycles) begin
            cycles++;
            @(negedge clk);
        end
        ok = iresp.addr_ok;
        if (!ok) begin
            report_error($sformatf("no addr_ok within %0d cycles for address %h",
                                   timeout_cycles, ireq.addr));
        end
    endtask

    initial begin
        int   gap;
        int   cycles;
        logic ok;
        resetn           = 1'b1;
        ireq             = '0;
        lfsr             = lfsr_seed;
        checking         = 1'b0;
        busy             = 1'b0;
        req_valid_prev   = 1'b0;
        refill_addr      = '0;
        arrived          = '0;
        beat_count       = 0;
        data_expected    = 1'b0;
        data_exp         = '0;
        error_count      = 0;
        miss_count       = 0;
        req_count        = 0;
        hit_count        = 0;
        refill_hit_count = 0;
        for (int s = 0; s < SETS; s++) begin
            model_plru[s] = '0;
            for (int w = 0; w < WAYS; w++) begin
                model_valid[s][w] = 1'b0;
                model_tag[s][w]   = '0;
            end
        end
        repeat (16) @(posedge clk);
        #1;
        resetn   = 1'b0;
        checking = 1'b1;
        // quiet bus after reset
        repeat (8) begin
            @(posedge clk);
            #1;
        end
        ok = 1'b1;
        for (int n = 0; n < num_requests && ok; n++) begin
            gap = int'(rand_bits(2));
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
            ireq.valid = 1'b1;
            ireq.addr  = next_addr();
            wait_accept(ok);
            @(posedge clk);
            #1;
            ireq = '0;
        end
        cycles = 0;
        while ((busy || data_expected) && cycles < timeout_cycles) begin
            cycles++;
            @(negedge clk);
        end
        if (busy || data_expected) begin
            report_error("last refill did not finish");
        end
        repeat (2) @(negedge clk);
        if (miss_count != req_count) begin
            report_mismatch("memory request count", req_count, miss_count);
        end
        $display("errors %0d, hits %0d (%0d during refill), misses %0d, memory requests %0d",
                 error_count, hit_count, refill_hit_count, miss_count, req_count);
        if (error_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
hw/bus_pkg.sv
hw/icache_pkg.sv
hw/icache_tag_array.sv
hw/icache_data_array.sv
hw/icache_fill_tracker.sv
hw/icache_refill_ctrl.sv
hw/icache.sv
tests/icache_mem_model.sv
tests/icache_tb.sv

// ==== Bender.yml ====
package:
  name: icache

sources:
  - files:
      - hw/bus_pkg.sv
      - hw/icache_pkg.sv
      - hw/icache_tag_array.sv
      - hw/icache_data_array.sv
      - hw/icache_fill_tracker.sv
      - hw/icache_refill_ctrl.sv
      - hw/icache.sv
  - target: test
    files:
      - tests/icache_mem_model.sv
      - tests/icache_tb.sv
